// File: include/ex_defs.svh
////////////////////////////////////////////////////////////////////////////
// execute stage encodings: ALU function codes, operand select codes
// and the architectural zero register
////////////////////////////////////////////////////////////////////////////

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// ALU function codes, 5 bits
////////////////////////////////////////////////////////////////////////////

`define EX_ALU_ADDQ    5'h00
`define EX_ALU_SUBQ    5'h01
`define EX_ALU_AND     5'h02
`define EX_ALU_BIC     5'h03  // a and not b
`define EX_ALU_BIS     5'h04  // plain or
`define EX_ALU_ORNOT   5'h05
`define EX_ALU_XOR     5'h06
`define EX_ALU_EQV     5'h07  // xnor
`define EX_ALU_SRL     5'h08
`define EX_ALU_SLL     5'h09
`define EX_ALU_SRA     5'h0a
`define EX_ALU_CMPULT  5'h0b
`define EX_ALU_CMPEQ   5'h0c
`define EX_ALU_CMPULE  5'h0d
`define EX_ALU_CMPLT   5'h0e
`define EX_ALU_CMPLE   5'h0f
// codes 16..31 unused, alu returns zero

////////////////////////////////////////////////////////////////////////////
// operand select codes
////////////////////////////////////////////////////////////////////////////

`define EX_OPA_REGA      2'h0
`define EX_OPA_MEM_DISP  2'h1
`define EX_OPA_NPC       2'h2
`define EX_OPA_NOT3      2'h3  // ~3, used to align jump targets

`define EX_OPB_REGB      2'h0
`define EX_OPB_ALU_IMM   2'h1
`define EX_OPB_BR_DISP   2'h2
// opb code 3 is undefined

// register 31 reads as zero and is never written
`define EX_ZERO_REG      5'd31

`endif

// File: hw/ex_pkg.sv
////////////////////////////////////////////////////////////////////////////
// execute stage types shared by the lanes and the top level
////////////////////////////////////////////////////////////////////////////

package ex_pkg;

  // data path
  typedef logic [63:0] word_t;      // operands, results, npc, targets
  typedef logic [31:0] inst_t;      // raw instruction word

  // register indices
  typedef logic [4:0]  ar_idx_t;    // architectural
  typedef logic [6:0]  pr_idx_t;    // physical

  // decoded control fields
  typedef logic [4:0]  alu_func_t;
  typedef logic [1:0]  opa_sel_t;
  typedef logic [1:0]  opb_sel_t;

  // bit 64 is predicted taken, bits 63:0 the predicted target
  typedef logic [64:0] pred_addr_t;

endpackage

// File: hw/alu.sv
////////////////////////////////////////////////////////////////////////////
// 64-bit integer ALU, purely combinational
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defs.svh"

module alu
(
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output ex_pkg::word_t     result
);

  // signed less-than on unsigned vectors
  function automatic logic signed_lt(input ex_pkg::word_t a, input ex_pkg::word_t b);
    if (a[63] == b[63])
    begin
      return a < b;      // same sign, unsigned order holds
    end
    else
    begin
      return a[63];      // a negative means a is smaller
    end
  endfunction

  logic [5:0] shamt;     // shift amount, low six bits of b
  logic       lt_s;      // signed a < b
  logic       eq;

  assign shamt = opb[5:0];
  assign lt_s  = signed_lt(opa, opb);
  assign eq    = (opa == opb);

  always_comb
  begin
    case (func)
      `EX_ALU_ADDQ:   result = opa + opb;
      `EX_ALU_SUBQ:   result = opa - opb;
      `EX_ALU_AND:    result = opa & opb;
      `EX_ALU_BIC:    result = opa & ~opb;
      `EX_ALU_BIS:    result = opa | opb;
      `EX_ALU_ORNOT:  result = opa | ~opb;
      `EX_ALU_XOR:    result = opa ^ opb;
      `EX_ALU_EQV:    result = opa ^ ~opb;
      `EX_ALU_SRL:    result = opa >> shamt;
      `EX_ALU_SLL:    result = opa << shamt;
      `EX_ALU_SRA:    result = ex_pkg::word_t'($signed(opa) >>> shamt); // sign fill
      // compares give 0/1 in bit 0
      `EX_ALU_CMPULT: result = {63'd0, opa < opb};
      `EX_ALU_CMPEQ:  result = {63'd0, eq};
      `EX_ALU_CMPULE: result = {63'd0, opa <= opb};
      `EX_ALU_CMPLT:  result = {63'd0, lt_s};
      `EX_ALU_CMPLE:  result = {63'd0, lt_s | eq};
      default:        result = '0;   // unused codes
    endcase
  end

endmodule

// File: hw/br_cond.sv
////////////////////////////////////////////////////////////////////////////
// branch condition tester on the register A value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module br_cond
(
  input  ex_pkg::word_t opa,   // register A value
  input  logic [2:0]    func,  // instruction bits 28:26
  output logic          cond
);

  logic raw;   // condition before the invert bit

  always_comb
  begin
    case (func[1:0])
      2'b00:   raw = ~opa[0];                 // low bit clear
      2'b01:   raw = (opa == '0);             // equal zero
      2'b10:   raw = opa[63];                 // negative
      default: raw = opa[63] | (opa == '0);   // not greater than zero
    endcase
  end

  // top bit selects the complementary test
  assign cond = raw ^ func[2];

endmodule

// File: hw/operand_select.sv
////////////////////////////////////////////////////////////////////////////
// immediate extraction and operand A/B multiplexers for one lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defs.svh"

module operand_select
(
  input  ex_pkg::inst_t    ir,
  input  ex_pkg::word_t    npc,
  input  ex_pkg::word_t    pra,
  input  ex_pkg::word_t    prb,
  input  ex_pkg::opa_sel_t opa_sel,
  input  ex_pkg::opb_sel_t opb_sel,
  output ex_pkg::word_t    opa,
  output ex_pkg::word_t    opb
);

  ex_pkg::word_t mem_disp;   // sign-extended 16-bit displacement
  ex_pkg::word_t br_disp;    // sign-extended 21-bit displacement, x4
  ex_pkg::word_t alu_imm;    // zero-extended 8-bit literal

  assign mem_disp = {{48{ir[15]}}, ir[15:0]};
  assign br_disp  = {{41{ir[20]}}, ir[20:0], 2'b00};
  assign alu_imm  = {56'd0, ir[20:13]};

  ////////////////////////////////////////////////////////////////////////////
  // operand A
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (opa_sel)
      `EX_OPA_REGA:     opa = pra;
      `EX_OPA_MEM_DISP: opa = mem_disp;
      `EX_OPA_NPC:      opa = npc;
      `EX_OPA_NOT3:     opa = ~64'h3;   // mask for jump targets
      default:          opa = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand B
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (opb_sel)
      `EX_OPB_REGB:     opb = prb;
      `EX_OPB_ALU_IMM:  opb = alu_imm;
      `EX_OPB_BR_DISP:  opb = br_disp;
      default:          opb = '0;       // undefined select
    endcase
  end

endmodule

// File: hw/alu_lane.sv
////////////////////////////////////////////////////////////////////////////
// one execute lane: operands, ALU, branch resolution and a completion
// entry held until the CDB grants it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defs.svh"

module alu_lane
(
  input  logic               clock,
  input  logic               reset,
  // issue side
  input  logic               valid_inst,
  input  ex_pkg::word_t      npc,
  input  ex_pkg::inst_t      ir,
  input  ex_pkg::word_t      pra,
  input  ex_pkg::word_t      prb,
  input  ex_pkg::ar_idx_t    dest_ar,
  input  ex_pkg::pr_idx_t    dest_pr,
  input  ex_pkg::opa_sel_t   opa_sel,
  input  ex_pkg::opb_sel_t   opb_sel,
  input  ex_pkg::alu_func_t  alu_func,
  input  logic               cond_branch,
  input  logic               uncond_branch,
  input  ex_pkg::pred_addr_t pred_addr,
  input  logic               cdb_grant,
  output logic               alu_avail,
  // completion side
  output logic               complete,
  output ex_pkg::word_t      result,
  output logic               write_enable,
  output ex_pkg::ar_idx_t    cdb_dest_ar,
  output ex_pkg::pr_idx_t    cdb_dest_pr,
  output logic               take_branch,
  output logic               exception
);

  ex_pkg::word_t opa;
  ex_pkg::word_t opb;
  ex_pkg::word_t alu_out;
  logic          br_true;     // condition on reg A holds
  logic          taken;       // resolved direction
  logic          mispredict;
  logic          accept;

  operand_select operand_select_i (
    .ir(ir), .npc(npc), .pra(pra), .prb(prb),
    .opa_sel(opa_sel), .opb_sel(opb_sel),
    .opa(opa), .opb(opb)
  );

  alu alu_i (.opa(opa), .opb(opb), .func(alu_func), .result(alu_out));

  br_cond br_cond_i (.opa(pra), .func(ir[28:26]), .cond(br_true));

  assign taken = uncond_branch | (cond_branch & br_true);

  // direction wrong, or taken with a wrong target
  assign mispredict = (cond_branch | uncond_branch)
                    & ((taken != pred_addr[64]) | (taken & (alu_out != pred_addr[63:0])));

  ////////////////////////////////////////////////////////////////////////////
  // completion entry, one deep
  ////////////////////////////////////////////////////////////////////////////

  assign alu_avail = ~complete | cdb_grant;   // empty, or retiring this edge
  assign accept    = valid_inst & alu_avail;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      complete     <= 1'b0;
      write_enable <= 1'b0;
      take_branch  <= 1'b0;
      exception    <= 1'b0;
    end
    else if (accept)
    begin
      complete     <= 1'b1;
      write_enable <= (dest_ar != `EX_ZERO_REG);  // r31 never written
      take_branch  <= taken;
      exception    <= mispredict;
    end
    else if (cdb_grant)
    begin
      complete     <= 1'b0;   // retired, nothing behind it
      write_enable <= 1'b0;
      take_branch  <= 1'b0;
      exception    <= 1'b0;
    end
  end

  // payload, only meaningful while complete
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      result      <= alu_out;
      cdb_dest_ar <= dest_ar;
      cdb_dest_pr <= dest_pr;
    end
  end

endmodule

// File: hw/alu_ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// integer execute stage top: two independent ALU lanes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module alu_ex_stage
(
  input  logic               clock,
  input  logic               reset,
  // lane 0 issue
  input  logic               valid_inst_0,
  input  ex_pkg::word_t      npc_0,
  input  ex_pkg::inst_t      ir_0,
  input  ex_pkg::word_t      pra_0,
  input  ex_pkg::word_t      prb_0,
  input  ex_pkg::ar_idx_t    dest_ar_0,
  input  ex_pkg::pr_idx_t    dest_pr_0,
  input  ex_pkg::opa_sel_t   opa_sel_0,
  input  ex_pkg::opb_sel_t   opb_sel_0,
  input  ex_pkg::alu_func_t  alu_func_0,
  input  logic               cond_branch_0,
  input  logic               uncond_branch_0,
  input  ex_pkg::pred_addr_t pred_addr_0,
  input  logic               cdb_grant_0,
  // lane 1 issue
  input  logic               valid_inst_1,
  input  ex_pkg::word_t      npc_1,
  input  ex_pkg::inst_t      ir_1,
  input  ex_pkg::word_t      pra_1,
  input  ex_pkg::word_t      prb_1,
  input  ex_pkg::ar_idx_t    dest_ar_1,
  input  ex_pkg::pr_idx_t    dest_pr_1,
  input  ex_pkg::opa_sel_t   opa_sel_1,
  input  ex_pkg::opb_sel_t   opb_sel_1,
  input  ex_pkg::alu_func_t  alu_func_1,
  input  logic               cond_branch_1,
  input  logic               uncond_branch_1,
  input  ex_pkg::pred_addr_t pred_addr_1,
  input  logic               cdb_grant_1,
  output logic [1:0]         alu_avail,     // bit n for lane n
  // lane 0 completion
  output logic               complete_0,
  output ex_pkg::word_t      result_0,
  output logic               write_enable_0,
  output ex_pkg::ar_idx_t    cdb_dest_ar_0,
  output ex_pkg::pr_idx_t    cdb_dest_pr_0,
  output logic               take_branch_0,
  output logic               exception_0,
  // lane 1 completion
  output logic               complete_1,
  output ex_pkg::word_t      result_1,
  output logic               write_enable_1,
  output ex_pkg::ar_idx_t    cdb_dest_ar_1,
  output ex_pkg::pr_idx_t    cdb_dest_pr_1,
  output logic               take_branch_1,
  output logic               exception_1
);

  // lanes share nothing but clock and reset
  alu_lane alu_lane_0 (
    .clock(clock), .reset(reset),
    .valid_inst(valid_inst_0), .npc(npc_0), .ir(ir_0),
    .pra(pra_0), .prb(prb_0),
    .dest_ar(dest_ar_0), .dest_pr(dest_pr_0),
    .opa_sel(opa_sel_0), .opb_sel(opb_sel_0), .alu_func(alu_func_0),
    .cond_branch(cond_branch_0), .uncond_branch(uncond_branch_0),
    .pred_addr(pred_addr_0), .cdb_grant(cdb_grant_0),
    .alu_avail(alu_avail[0]),
    .complete(complete_0), .result(result_0), .write_enable(write_enable_0),
    .cdb_dest_ar(cdb_dest_ar_0), .cdb_dest_pr(cdb_dest_pr_0),
    .take_branch(take_branch_0), .exception(exception_0)
  );

  alu_lane alu_lane_1 (
    .clock(clock), .reset(reset),
    .valid_inst(valid_inst_1), .npc(npc_1), .ir(ir_1),
    .pra(pra_1), .prb(prb_1),
    .dest_ar(dest_ar_1), .dest_pr(dest_pr_1),
    .opa_sel(opa_sel_1), .opb_sel(opb_sel_1), .alu_func(alu_func_1),
    .cond_branch(cond_branch_1), .uncond_branch(uncond_branch_1),
    .pred_addr(pred_addr_1), .cdb_grant(cdb_grant_1),
    .alu_avail(alu_avail[1]),
    .complete(complete_1), .result(result_1), .write_enable(write_enable_1),
    .cdb_dest_ar(cdb_dest_ar_1), .cdb_dest_pr(cdb_dest_pr_1),
    .take_branch(take_branch_1), .exception(exception_1)
  );

endmodule

// File: verification/alu_ex_stage_chk.sv
////////////////////////////////////////////////////////////////////////////
// lane handshake checks, bound into every alu_lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defs.svh"

module alu_ex_stage_chk
(
  input logic            clock,
  input logic            reset,
  input logic            valid_inst,
  input logic            cdb_grant,
  input logic            alu_avail,
  input logic            complete,
  input ex_pkg::word_t   result,
  input logic            write_enable,
  input ex_pkg::ar_idx_t cdb_dest_ar,
  input ex_pkg::pr_idx_t cdb_dest_pr,
  input logic            take_branch,
  input logic            exception
);

  // a waiting entry holds still until the bus takes it
  hold_stable: assert property (@(posedge clock) disable iff (reset)
    complete && !cdb_grant |=> complete && $stable(result) && $stable(write_enable)
      && $stable(cdb_dest_ar) && $stable(cdb_dest_pr)
      && $stable(take_branch) && $stable(exception))
    else $error("completion entry changed while waiting for a grant");

  // open lane taking nothing is left empty, so it stays open
  avail_when_empty: assert property (@(posedge clock) disable iff (reset)
    alu_avail && !valid_inst |=> !complete && alu_avail)
    else $error("lane empty but not available");

  // r31 is never a write target
  no_zero_write: assert property (@(posedge clock) disable iff (reset)
    write_enable |-> cdb_dest_ar != `EX_ZERO_REG)
    else $error("write enable raised for the zero register");

endmodule

bind alu_lane alu_ex_stage_chk alu_ex_stage_chk_i (
  .clock(clock), .reset(reset), .valid_inst(valid_inst),
  .cdb_grant(cdb_grant), .alu_avail(alu_avail),
  .complete(complete), .result(result), .write_enable(write_enable),
  .cdb_dest_ar(cdb_dest_ar), .cdb_dest_pr(cdb_dest_pr),
  .take_branch(take_branch), .exception(exception)
);

// File: verification/alu_ex_stage_tb.sv
////////////////////////////////////////////////////////////////////////////
// execute stage testbench: random issue and grant streams on both lanes
// checked against a per-lane reference model and scoreboard
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defs.svh"

module alu_ex_stage_tb;

  localparam int          PERIOD_NS    = 4;
  localparam int          RESET_CYCLES = 4;
  localparam int          RUN_CYCLES   = 5000;   // random issue phase
  localparam int          DRAIN_CYCLES = 8;      // allowance to empty both lanes
  localparam int          CYCLE_MARGIN = 3;
  localparam logic [63:0] SEED         = 64'd70500;
  localparam int          WATCHDOG_NS  =
    (RESET_CYCLES + RUN_CYCLES + DRAIN_CYCLES) * CYCLE_MARGIN * PERIOD_NS;

  // one scoreboard entry, same order as the completion outputs
  typedef struct packed {
    ex_pkg::word_t   result;
    logic            write_enable;
    ex_pkg::ar_idx_t dest_ar;
    ex_pkg::pr_idx_t dest_pr;
    logic            take_branch;
    logic            exception;
  } entry_t;

  logic clock = 1'b0;
  logic reset;

  // issue side, index is the lane
  logic               valid_inst [2];
  ex_pkg::word_t      npc [2];
  ex_pkg::inst_t      ir [2];
  ex_pkg::word_t      pra [2];
  ex_pkg::word_t      prb [2];
  ex_pkg::ar_idx_t    dest_ar [2];
  ex_pkg::pr_idx_t    dest_pr [2];
  ex_pkg::opa_sel_t   opa_sel [2];
  ex_pkg::opb_sel_t   opb_sel [2];
  ex_pkg::alu_func_t  alu_func [2];
  logic               cond_branch [2];
  logic               uncond_branch [2];
  ex_pkg::pred_addr_t pred_addr [2];
  logic               cdb_grant [2];
  logic [1:0]         alu_avail;

  // completion side
  logic               complete [2];
  ex_pkg::word_t      result [2];
  logic               write_enable [2];
  ex_pkg::ar_idx_t    cdb_dest_ar [2];
  ex_pkg::pr_idx_t    cdb_dest_pr [2];
  logic               take_branch [2];
  logic               exception [2];

  entry_t      exp_q0 [$];     // lane 0 model, issue order
  entry_t      exp_q1 [$];
  logic [63:0] rng_state;
  string       test_name;
  logic        run_done;
  logic        fail_printed;

  alu_ex_stage alu_ex_stage_i (
    .clock(clock), .reset(reset),
    .valid_inst_0(valid_inst[0]), .npc_0(npc[0]), .ir_0(ir[0]), .pra_0(pra[0]),
    .prb_0(prb[0]), .dest_ar_0(dest_ar[0]), .dest_pr_0(dest_pr[0]),
    .opa_sel_0(opa_sel[0]), .opb_sel_0(opb_sel[0]), .alu_func_0(alu_func[0]),
    .cond_branch_0(cond_branch[0]), .uncond_branch_0(uncond_branch[0]),
    .pred_addr_0(pred_addr[0]), .cdb_grant_0(cdb_grant[0]),
    .valid_inst_1(valid_inst[1]), .npc_1(npc[1]), .ir_1(ir[1]), .pra_1(pra[1]),
    .prb_1(prb[1]), .dest_ar_1(dest_ar[1]), .dest_pr_1(dest_pr[1]),
    .opa_sel_1(opa_sel[1]), .opb_sel_1(opb_sel[1]), .alu_func_1(alu_func[1]),
    .cond_branch_1(cond_branch[1]), .uncond_branch_1(uncond_branch[1]),
    .pred_addr_1(pred_addr[1]), .cdb_grant_1(cdb_grant[1]),
    .alu_avail(alu_avail),
    .complete_0(complete[0]), .result_0(result[0]), .write_enable_0(write_enable[0]),
    .cdb_dest_ar_0(cdb_dest_ar[0]), .cdb_dest_pr_0(cdb_dest_pr[0]),
    .take_branch_0(take_branch[0]), .exception_0(exception[0]),
    .complete_1(complete[1]), .result_1(result[1]), .write_enable_1(write_enable[1]),
    .cdb_dest_ar_1(cdb_dest_ar[1]), .cdb_dest_pr_1(cdb_dest_pr[1]),
    .take_branch_1(take_branch[1]), .exception_1(exception[1])
  );

  always #(PERIOD_NS / 2) clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // bias operands toward zero, small and sign-crossing values
  function automatic ex_pkg::word_t shaped(input logic [63:0] r);
    case (r[1:0])
      2'd0:    return r;
      2'd1:    return {61'd0, r[4:2]};          // tiny, often zero
      2'd2:    return ~{56'd0, r[9:2]};         // small negative
      default: return {r[63], 57'd0, r[7:2]};   // sign bit plus a short tail
    endcase
  endfunction

  function automatic ex_pkg::word_t model_opa(input ex_pkg::opa_sel_t sel,
                                              input ex_pkg::inst_t i,
                                              input ex_pkg::word_t pc,
                                              input ex_pkg::word_t a);
    case (sel)
      `EX_OPA_REGA:     return a;
      `EX_OPA_MEM_DISP: return 64'($signed(i[15:0]));
      `EX_OPA_NPC:      return pc;
      default:          return 64'hffff_ffff_ffff_fffc;
    endcase
  endfunction

  function automatic ex_pkg::word_t model_opb(input ex_pkg::opb_sel_t sel,
                                              input ex_pkg::inst_t i,
                                              input ex_pkg::word_t b);
    case (sel)
      `EX_OPB_REGB:    return b;
      `EX_OPB_ALU_IMM: return 64'(i[20:13]);
      `EX_OPB_BR_DISP: return 64'($signed({i[20:0], 2'b00}));   // word offset
      default:         return 64'd0;
    endcase
  endfunction

  function automatic ex_pkg::word_t model_alu(input ex_pkg::alu_func_t f,
                                              input ex_pkg::word_t a,
                                              input ex_pkg::word_t b);
    case (f)
      `EX_ALU_ADDQ:   return a + b;
      `EX_ALU_SUBQ:   return a - b;
      `EX_ALU_AND:    return a & b;
      `EX_ALU_BIC:    return a & ~b;
      `EX_ALU_BIS:    return a | b;
      `EX_ALU_ORNOT:  return a | ~b;
      `EX_ALU_XOR:    return a ^ b;
      `EX_ALU_EQV:    return ~(a ^ b);
      `EX_ALU_SRL:    return a >> b[5:0];
      `EX_ALU_SLL:    return a << b[5:0];
      // vacated top bits take the sign
      `EX_ALU_SRA:    return (a >> b[5:0])
                             | ({64{a[63]}} & ~(64'hffff_ffff_ffff_ffff >> b[5:0]));
      `EX_ALU_CMPULT: return {63'd0, a < b};
      `EX_ALU_CMPEQ:  return {63'd0, a == b};
      `EX_ALU_CMPULE: return {63'd0, a <= b};
      `EX_ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
      `EX_ALU_CMPLE:  return {63'd0, $signed(a) <= $signed(b)};
      default:        return 64'd0;
    endcase
  endfunction

  function automatic logic model_cond(input logic [2:0] f, input ex_pkg::word_t a);
    logic base;
    case (f[1:0])
      2'd0:    base = (a[0] == 1'b0);
      2'd1:    base = (a == 64'd0);
      2'd2:    base = ($signed(a) < 64'sd0);
      default: base = ($signed(a) <= 64'sd0);
    endcase
    return f[2] ? !base : base;   // bit 2 flips the sense
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // error handling
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    fail_printed = 1'b1;
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_bit(input string what, input int n, input logic want,
                            input logic got);
    $display("error: %s lane %0d %s expected %b actual %b", test_name, n, what, want, got);
    fail_run();
  endtask

  task automatic report_entry(input int n, input entry_t want, input entry_t got);
    $display("error: %s lane %0d entry expected %h actual %h", test_name, n, want, got);
    fail_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and checks, one lane at a time
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_lane(input int n);
    valid_inst[n]    = 1'b0;
    npc[n]           = '0;
    ir[n]            = '0;
    pra[n]           = '0;
    prb[n]           = '0;
    dest_ar[n]       = '0;
    dest_pr[n]       = '0;
    opa_sel[n]       = '0;
    opb_sel[n]       = '0;
    alu_func[n]      = '0;
    cond_branch[n]   = 1'b0;
    uncond_branch[n] = 1'b0;
    pred_addr[n]     = '0;
    cdb_grant[n]     = 1'b0;
  endtask

  task automatic drive_lane(input int n);
    logic [63:0]   r;
    logic [63:0]   s;
    ex_pkg::word_t target;
    r = xorshift();
    s = xorshift();
    valid_inst[n]    = (r[1:0] != 2'd0);
    cdb_grant[n]     = (r[4:2] > 3'd2);   // about 5 in 8, leaves back-pressure
    dest_ar[n]       = (r[7:5] == 3'd0) ? `EX_ZERO_REG : r[12:8];
    dest_pr[n]       = r[19:13];
    cond_branch[n]   = (r[22:21] == 2'd0);
    uncond_branch[n] = (r[22:20] == 3'd2);
    if (cond_branch[n] || uncond_branch[n])
    begin
      opa_sel[n]  = r[23] ? `EX_OPA_NPC : `EX_OPA_NOT3;      // pc relative or jump
      opb_sel[n]  = r[23] ? `EX_OPB_BR_DISP : `EX_OPB_REGB;
      alu_func[n] = r[23] ? `EX_ALU_ADDQ : `EX_ALU_AND;
    end
    else
    begin
      opa_sel[n]  = r[25:24];
      opb_sel[n]  = r[27:26];   // code 3 included
      alu_func[n] = (r[30:28] == 3'd0) ? r[35:31] : {1'b0, r[34:31]};
    end
    ir[n]  = s[31:0];
    npc[n] = xorshift() & ~64'h3;
    pra[n] = shaped(xorshift());
    prb[n] = (r[38:36] == 3'd0) ? pra[n] : shaped(xorshift());
    target = model_alu(alu_func[n], model_opa(opa_sel[n], ir[n], npc[n], pra[n]),
                       model_opb(opb_sel[n], ir[n], prb[n]));
    pred_addr[n] = {r[39], r[40] ? target : xorshift()};   // right or wrong target
  endtask

  // runs between a falling edge and the next rising edge
  task automatic check_lane(input int n);
    entry_t        want;
    entry_t        got;
    ex_pkg::word_t res;
    logic          taken;
    logic          avail_exp;
    int            depth;
    depth     = (n == 0) ? exp_q0.size() : exp_q1.size();
    avail_exp = (depth == 0) || cdb_grant[n];   // empty, or retiring at this edge
    assert (alu_avail[n] == avail_exp)
    else report_bit("alu_avail", n, avail_exp, alu_avail[n]);
    assert (complete[n] == (depth != 0))   // nothing lost, nothing extra
    else report_bit("complete", n, depth != 0, complete[n]);
    if ((depth != 0) && cdb_grant[n])
    begin
      if (n == 0)
        want = exp_q0.pop_front();
      else
        want = exp_q1.pop_front();
      got = {result[n], write_enable[n], cdb_dest_ar[n], cdb_dest_pr[n],
             take_branch[n], exception[n]};
      assert (got == want)
      else report_entry(n, want, got);
    end
    if (valid_inst[n] && avail_exp)
    begin
      res   = model_alu(alu_func[n], model_opa(opa_sel[n], ir[n], npc[n], pra[n]),
                        model_opb(opb_sel[n], ir[n], prb[n]));
      taken = uncond_branch[n] || (cond_branch[n] && model_cond(ir[n][28:26], pra[n]));
      want.result       = res;
      want.write_enable = (dest_ar[n] != `EX_ZERO_REG);
      want.dest_ar      = dest_ar[n];
      want.dest_pr      = dest_pr[n];
      want.take_branch  = taken;
      want.exception    = (cond_branch[n] || uncond_branch[n])
                        && ((taken != pred_addr[n][64])
                            || (taken && (res != pred_addr[n][63:0])));
      if (n == 0)
        exp_q0.push_back(want);
      else
        exp_q1.push_back(want);
    end
  endtask

  task automatic check_reset_state();
    for (int n = 0; n < 2; n++)
    begin
      assert (!complete[n]) else report_bit("complete", n, 1'b0, complete[n]);
      assert (!write_enable[n]) else report_bit("write_enable", n, 1'b0, write_enable[n]);
      assert (!take_branch[n]) else report_bit("take_branch", n, 1'b0, take_branch[n]);
      assert (!exception[n]) else report_bit("exception", n, 1'b0, exception[n]);
      assert (alu_avail[n]) else report_bit("alu_avail", n, 1'b1, alu_avail[n]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rng_state    = SEED;
    run_done     = 1'b0;
    fail_printed = 1'b0;
    test_name    = "reset_state";
    reset        = 1'b1;
    idle_lane(0);
    idle_lane(1);
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    check_reset_state();

    // both lanes, independent valid, grant and op streams
    test_name = "random_ops";
    repeat (RUN_CYCLES)
    begin
      @(negedge clock);
      drive_lane(0);
      drive_lane(1);
      #1;
      check_lane(0);
      check_lane(1);
    end

    // grant everything until both lanes are empty
    test_name = "drain";
    while (exp_q0.size() != 0 || exp_q1.size() != 0 || complete[0] || complete[1])
    begin
      @(negedge clock);
      idle_lane(0);
      idle_lane(1);
      cdb_grant[0] = 1'b1;
      cdb_grant[1] = 1'b1;
      #1;
      check_lane(0);
      check_lane(1);
    end

    if (!fail_printed)
    begin
      run_done = 1'b1;
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      fail_run();
    end
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    fail_run();
  end

  // a bound assertion can end the run without passing through the sequence
  final
  begin
    if (!run_done && !fail_printed)
      $display("*** TEST FAILED ***");
  end

endmodule

// File: alu_ex_stage.f
+incdir+include
hw/ex_pkg.sv
hw/alu.sv
hw/br_cond.sv
hw/operand_select.sv
hw/alu_lane.sv
hw/alu_ex_stage.sv
verification/alu_ex_stage_chk.sv
verification/alu_ex_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= alu_ex_stage_tb
FILELIST  ?= alu_ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulator status is ignored, the log decides
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation gave no result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
